/* sources.f */
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/decode_if.sv
source/inst_decoder.sv
source/regfile.sv
source/operand_fetch.sv
source/decode_top.sv
testbench/decode_asserts.sv
testbench/decode_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the decode stage simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module decode_tb \
	-o decode_sim

./obj_dir/decode_sim | tee sim.log

if grep -q "Done: no errors" sim.log; then
	exit 0
else
	exit 1
fi

/* testbench/decode_tb.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module decode_tb;
	import isa_pkg::*;

	// upper bound on issued instructions for the watchdog
	localparam int NUM_TESTS = 100;

	// expected operand bundle
	typedef struct packed {
		logic [31:0] pc;
		alu_op_t     alu_op;
		br_kind_t    br_kind;
		logic        br_from_reg;
		logic        src1_is_pc;
		logic        src2_is_imm;
		logic        src2_is_4;
		logic [31:0] imm;
		logic [31:0] rj;
		logic [31:0] rkd;
		logic [4:0]  dest;
		logic        gpr_we;
		logic        mem_we;
		logic        res_from_mem;
		mem_size_t   mem_size;
		logic        mem_signed;
		logic [5:0]  ecode;
	} bundle_t;

	logic clk, reset, in_valid, wb_we;
	logic [31:0] inst, pc, wb_data;
	logic [5:0] fetch_ecode;
	logic [4:0] wb_addr;
	logic out_valid, br_from_reg, src1_is_pc, src2_is_imm, src2_is_4;
	logic [31:0] out_pc, imm, rj_value, rkd_value;
	alu_op_t alu_op;
	br_kind_t br_kind;
	logic [4:0] dest;
	logic gpr_we, mem_we, res_from_mem, mem_signed;
	mem_size_t mem_size;
	logic [5:0] ecode;

	integer seed = 32'hcc6d_6d48;
	logic [31:0] shadow [32];
	logic [31:0] pc_next;
	bundle_t expected_q [$];

	// minor opcodes of the register ALU forms and their operations
	logic [6:0] r_ops [11] = '{7'h20, 7'h22, 7'h24, 7'h25, 7'h28, 7'h29,
		7'h2a, 7'h2b, 7'h2e, 7'h2f, 7'h30};
	alu_op_t r_alu [11] = '{ADD, SUB, SLT, SLTU, NOR, AND, OR, XOR, SLL, SRL, SRA};
	// immediate ALU forms by inst[25:22]
	logic [3:0] i_ops [6] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
	alu_op_t i_alu [6] = '{SLT, SLTU, ADD, AND, OR, XOR};
	// conditional branches beq .. bgeu
	alu_op_t b_alu [6] = '{EQ, EQ, SLT, SLT, SLTU, SLTU};

	decode_top dut_i (.*);

	bind decode_top decode_asserts u_asserts (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.fetch_ecode (fetch_ecode),
		.out_valid   (out_valid),
		.gpr_we      (gpr_we),
		.mem_we      (mem_we),
		.ecode       (ecode)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// end the run if the result queue never drains
	initial begin
		#((2000 + 4 * NUM_TESTS) * 4);
		$display("timeout: results did not arrive in time");
		$display("Done: errors found");
		$fatal(1);
	end

	// instruction encoders
	function automatic logic [31:0] enc_r3(input logic [6:0] op7, input logic [4:0] rk,
		input logic [4:0] rj, input logic [4:0] rd);
		return {10'b0, op7, rk, rj, rd};
	endfunction

	function automatic logic [31:0] enc_i12(input logic [9:0] op10, input logic [11:0] i12,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op10, i12, rj, rd};
	endfunction

	function automatic logic [31:0] enc_br(input logic [5:0] op6, input logic [15:0] off,
		input logic [4:0] rj, input logic [4:0] rd);
		return {op6, off, rj, rd};
	endfunction

	// all-quiet bundle with the given destination
	function automatic bundle_t blank(input logic [4:0] rd);
		bundle_t b;
		b = '0;
		b.alu_op = ADD;
		b.br_kind = NONE;
		b.mem_size = BYTE;
		b.dest = rd;
		return b;
	endfunction

	// next clock edge with inputs back to idle
	task automatic step();
		@(posedge clk);
		in_valid <= 1'b0;
		wb_we <= 1'b0;
		fetch_ecode <= 6'h00;
	endtask

	// write-back port drive mirrored in the shadow copy
	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		wb_we <= 1'b1;
		wb_addr <= addr;
		wb_data <= data;
		if (addr != 5'd0)
			shadow[addr] = data;
	endtask

	// strobe one instruction and queue its expected bundle
	task automatic send(input logic [31:0] word, input logic [5:0] fe, input bundle_t b,
		input logic [4:0] r1, input logic use1, input logic [4:0] r2, input logic use2);
		in_valid <= 1'b1;
		inst <= word;
		pc <= pc_next;
		fetch_ecode <= fe;
		b.pc = pc_next;
		b.rj = use1 ? shadow[r1] : 32'h0;
		b.rkd = use2 ? shadow[r2] : 32'h0;
		// fetch exception overrides and silences the instruction
		if (fe != 6'h00) begin
			b.ecode = fe;
			b.gpr_we = 1'b0;
			b.mem_we = 1'b0;
		end
		expected_q.push_back(b);
		pc_next = pc_next + 32'd4;
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// outputs settle half a cycle after the edge
	always @(negedge clk) begin
		bundle_t e;
		if (!reset && out_valid) begin
			assert (expected_q.size() != 0) else begin
				$display("out_valid rose with no instruction outstanding");
				$display("Done: errors found");
				$fatal(1);
			end
			e = expected_q.pop_front();
			check_val("out_pc", out_pc, e.pc);
			check_val("alu_op", 32'(alu_op), 32'(e.alu_op));
			check_val("br_kind", 32'(br_kind), 32'(e.br_kind));
			check_val("br_from_reg", 32'(br_from_reg), 32'(e.br_from_reg));
			check_val("src1_is_pc", 32'(src1_is_pc), 32'(e.src1_is_pc));
			check_val("src2_is_imm", 32'(src2_is_imm), 32'(e.src2_is_imm));
			check_val("src2_is_4", 32'(src2_is_4), 32'(e.src2_is_4));
			check_val("imm", imm, e.imm);
			check_val("rj_value", rj_value, e.rj);
			check_val("rkd_value", rkd_value, e.rkd);
			check_val("dest", 32'(dest), 32'(e.dest));
			check_val("gpr_we", 32'(gpr_we), 32'(e.gpr_we));
			check_val("mem_we", 32'(mem_we), 32'(e.mem_we));
			check_val("res_from_mem", 32'(res_from_mem), 32'(e.res_from_mem));
			check_val("mem_size", 32'(mem_size), 32'(e.mem_size));
			check_val("mem_signed", 32'(mem_signed), 32'(e.mem_signed));
			check_val("ecode", 32'(ecode), 32'(e.ecode));
		end
	end

	initial begin
		bundle_t b;
		logic [4:0] rd, rj, rk;
		logic [11:0] i12;
		logic [19:0] i20;
		logic [15:0] off;
		logic [25:0] off26;
		logic [31:0] fwd_data;
		reset = 1'b1;
		in_valid = 1'b0;
		inst = 32'h0;
		pc = 32'h0;
		fetch_ecode = 6'h00;
		wb_we = 1'b0;
		wb_addr = 5'd0;
		wb_data = 32'h0;
		pc_next = 32'h1c00_0000;
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'h0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// fill the register file through write-back
		for (int i = 1; i < 32; i++) begin
			step();
			write_reg(5'(i), $random(seed));
		end

		// register ALU back to back
		for (int k = 0; k < 12; k++) begin
			rd = 5'($random(seed));
			rk = 5'($random(seed));
			// last one reads r0
			rj = (k == 11) ? 5'd0 : 5'($random(seed));
			b = blank(rd);
			b.alu_op = r_alu[k % 11];
			b.gpr_we = 1'b1;
			step();
			send(enc_r3(r_ops[k % 11], rk, rj, rd), 6'h00, b, rj, 1'b1, rk, 1'b1);
		end

		// immediate ALU where logic ops zero extend
		for (int k = 0; k < 6; k++) begin
			rd = 5'($random(seed));
			rj = 5'($random(seed));
			i12 = 12'($random(seed)) | 12'h800;
			b = blank(rd);
			b.alu_op = i_alu[k];
			b.gpr_we = 1'b1;
			b.src2_is_imm = 1'b1;
			b.imm = (k >= 3) ? {20'h0, i12} : {{20{i12[11]}}, i12};
			step();
			send(enc_i12({6'b0, i_ops[k]}, i12, rj, rd), 6'h00, b, rj, 1'b1, 5'd0, 1'b0);
		end

		// shift immediates slli srli srai
		for (int k = 0; k < 3; k++) begin
			rd = 5'($random(seed));
			rj = 5'($random(seed));
			rk = 5'($random(seed));
			b = blank(rd);
			b.alu_op = (k == 0) ? SLL : (k == 1) ? SRL : SRA;
			b.gpr_we = 1'b1;
			b.src2_is_imm = 1'b1;
			b.imm = {27'h0, rk};
			step();
			send({10'b0000000001, 7'(8 * k + 1), rk, rj, rd}, 6'h00, b, rj, 1'b1, 5'd0, 1'b0);
		end

		// lu12i.w then pcaddu12i
		for (int k = 0; k < 2; k++) begin
			rd = 5'($random(seed));
			i20 = 20'($random(seed));
			b = blank(rd);
			b.alu_op = (k == 0) ? LUI : ADD;
			b.src1_is_pc = (k == 1);
			b.gpr_we = 1'b1;
			b.src2_is_imm = 1'b1;
			b.imm = {i20, 12'h000};
			step();
			send({(k == 0) ? 7'b0001010 : 7'b0001110, i20, rd}, 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);
		end

		// conditional branches read rj and rd
		for (int k = 0; k < 6; k++) begin
			rd = 5'($random(seed));
			rj = 5'($random(seed));
			off = 16'($random(seed));
			b = blank(rd);
			b.alu_op = b_alu[k];
			b.br_kind = (k % 2 == 0) ? IF_TRUE : IF_FALSE;
			b.imm = {{14{off[15]}}, off, 2'b00};
			step();
			send(enc_br(6'(6'h16 + k), off, rj, rd), 6'h00, b, rj, 1'b1, rd, 1'b1);
		end

		// jirl links pc+4 and jumps through rj
		rd = 5'($random(seed));
		rj = 5'($random(seed));
		off = 16'h8123;
		b = blank(rd);
		b.br_kind = ALWAYS;
		b.br_from_reg = 1'b1;
		b.src1_is_pc = 1'b1;
		b.src2_is_4 = 1'b1;
		b.gpr_we = 1'b1;
		b.imm = {{14{off[15]}}, off, 2'b00};
		step();
		send(enc_br(6'h13, off, rj, rd), 6'h00, b, rj, 1'b1, 5'd0, 1'b0);

		// b and bl with a 26-bit offset
		for (int k = 0; k < 2; k++) begin
			off26 = 26'($random(seed));
			b = blank((k == 1) ? 5'd1 : off26[20:16]);
			b.br_kind = ALWAYS;
			b.src1_is_pc = (k == 1);
			b.src2_is_4 = (k == 1);
			b.gpr_we = (k == 1);
			b.imm = {{4{off26[25]}}, off26, 2'b00};
			step();
			send(enc_br(6'(6'h14 + k), off26[15:0], off26[25:21], off26[20:16]), 6'h00, b,
				5'd0, 1'b0, 5'd0, 1'b0);
		end

		// loads ld.b ld.h ld.w ld.bu ld.hu
		for (int k = 0; k < 5; k++) begin
			rd = 5'($random(seed));
			rj = 5'($random(seed));
			i12 = 12'($random(seed));
			b = blank(rd);
			b.src2_is_imm = 1'b1;
			b.imm = {{20{i12[11]}}, i12};
			b.gpr_we = 1'b1;
			b.res_from_mem = 1'b1;
			b.mem_size = mem_size_t'(k % 3);
			b.mem_signed = (k < 3);
			step();
			send(enc_i12({6'b001010, (k < 3) ? 4'(k) : 4'(k + 5)}, i12, rj, rd), 6'h00, b,
				rj, 1'b1, 5'd0, 1'b0);
		end

		// stores st.b st.h st.w with data from rd
		for (int k = 0; k < 3; k++) begin
			rd = 5'($random(seed));
			rj = 5'($random(seed));
			i12 = 12'($random(seed));
			b = blank(rd);
			b.src2_is_imm = 1'b1;
			b.imm = {{20{i12[11]}}, i12};
			b.mem_we = 1'b1;
			b.mem_size = mem_size_t'(k);
			step();
			send(enc_i12({6'b001010, 4'(k + 4)}, i12, rj, rd), 6'h00, b, rj, 1'b1, rd, 1'b1);
		end

		// syscall and break carry a code field
		b = blank(5'h13);
		b.ecode = `ECODE_SYS;
		step();
		send({10'b0, 7'h56, 15'h0273}, 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);
		b = blank(5'h05);
		b.ecode = `ECODE_BRK;
		step();
		send({10'b0, 7'h54, 15'h0045}, 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);

		// reserved alu hole, ld type 011, st with bit 25 and an unused major
		b = blank(5'd3);
		b.ecode = `ECODE_INE;
		step();
		send(enc_r3(7'h21, 5'd1, 5'd2, 5'd3), 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);
		step();
		send(enc_i12(10'b0010100011, 12'h010, 5'd2, 5'd3), 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);
		step();
		send(enc_i12(10'b0010101100, 12'h010, 5'd2, 5'd3), 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);
		b = blank(5'h1f);
		b.ecode = `ECODE_INE;
		step();
		send(32'hffff_ffff, 6'h00, b, 5'd0, 1'b0, 5'd0, 1'b0);

		// fetch exception on a legal add.w and on a syscall
		b = blank(5'd7);
		b.gpr_we = 1'b1;
		step();
		send(enc_r3(7'h20, 5'd9, 5'd8, 5'd7), 6'h08, b, 5'd8, 1'b1, 5'd9, 1'b1);
		b = blank(5'd0);
		step();
		send({10'b0, 7'h56, 15'h0000}, 6'h21, b, 5'd0, 1'b0, 5'd0, 1'b0);

		// write-back in the read cycle is forwarded
		fwd_data = $random(seed);
		b = blank(5'd6);
		b.gpr_we = 1'b1;
		// operand carries the value written while it is read
		shadow[5] = fwd_data;
		step();
		send(enc_r3(7'h20, 5'd5, 5'd5, 5'd6), 6'h00, b, 5'd5, 1'b1, 5'd5, 1'b1);
		// a write to r0 in its read cycle still reads zero
		b.alu_op = AND;
		step();
		write_reg(5'd5, fwd_data);
		send(enc_r3(7'h29, 5'd0, 5'd0, 5'd6), 6'h00, b, 5'd0, 1'b1, 5'd0, 1'b1);
		step();
		write_reg(5'd0, 32'hdead_beef);

		// drain the pipeline
		for (int n = 0; n < 16 && expected_q.size() != 0; n++)
			step();
		if (expected_q.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("results missing for %0d instructions", expected_q.size());
			$display("Done: errors found");
			$fatal(1);
		end
	end

endmodule

/* testbench/decode_asserts.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module decode_asserts (
	input logic                clk,
	input logic                reset,
	input logic                in_valid,
	input logic [`ECODE_W-1:0] fetch_ecode,
	input logic                out_valid,
	input logic                gpr_we,
	input logic                mem_we,
	input logic [`ECODE_W-1:0] ecode
);

	// every strobe comes out two cycles later
	a_latency: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> ##2 out_valid)
		else $error("out_valid missing two cycles after in_valid");

	// no result without a strobe
	a_no_spurious: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> $past(in_valid, 2))
		else $error("out_valid without a strobe two cycles earlier");

	// reset clears the strobe and both write enables
	a_reset_quiet: assert property (@(posedge clk)
		reset |=> (!out_valid && !gpr_we && !mem_we))
		else $error("outputs active after reset");

	// write enables only with a valid bundle
	a_we_valid: assert property (@(posedge clk) disable iff (reset)
		(gpr_we || mem_we) |-> out_valid)
		else $error("write enable without out_valid");

	// excepting instruction has no side effect
	a_exc_quiet: assert property (@(posedge clk) disable iff (reset)
		(out_valid && ecode != `ECODE_NONE) |-> (!gpr_we && !mem_we))
		else $error("write enable set on an excepting instruction");

	// fetch exception code passes through untouched
	a_fetch_pass: assert property (@(posedge clk) disable iff (reset)
		(in_valid && fetch_ecode != `ECODE_NONE) |->
		##2 (ecode == $past(fetch_ecode, 2)))
		else $error("fetch exception code not passed through");

endmodule

/* source/decode_top.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module decode_top (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   in_valid,
	input  logic [`XLEN-1:0]       inst,
	input  logic [`XLEN-1:0]       pc,
	input  logic [`ECODE_W-1:0]    fetch_ecode,
	input  logic                   wb_we,
	input  logic [`REG_ADDR_W-1:0] wb_addr,
	input  logic [`XLEN-1:0]       wb_data,
	output logic                   out_valid,
	output logic [`XLEN-1:0]       out_pc,
	output isa_pkg::alu_op_t       alu_op,
	output isa_pkg::br_kind_t      br_kind,
	output logic                   br_from_reg,
	output logic                   src1_is_pc,
	output logic                   src2_is_imm,
	output logic                   src2_is_4,
	output logic [`XLEN-1:0]       imm,
	output logic [`XLEN-1:0]       rj_value,
	output logic [`XLEN-1:0]       rkd_value,
	output logic [`REG_ADDR_W-1:0] dest,
	output logic                   gpr_we,
	output logic                   mem_we,
	output logic                   res_from_mem,
	output isa_pkg::mem_size_t     mem_size,
	output logic                   mem_signed,
	output logic [`ECODE_W-1:0]    ecode
);
	// decode to operand stage
	decode_if dec_bus ();

	// stage 1, decode and classify
	inst_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.in_valid    (in_valid),
		.inst        (inst),
		.pc          (pc),
		.fetch_ecode (fetch_ecode),
		.dec         (dec_bus.producer)
	);

	// stage 2, register read and output bundle
	operand_fetch u_operand (
		.clk          (clk),
		.reset        (reset),
		.dec          (dec_bus.consumer),
		.wb_we        (wb_we),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.alu_op       (alu_op),
		.br_kind      (br_kind),
		.br_from_reg  (br_from_reg),
		.src1_is_pc   (src1_is_pc),
		.src2_is_imm  (src2_is_imm),
		.src2_is_4    (src2_is_4),
		.imm          (imm),
		.rj_value     (rj_value),
		.rkd_value    (rkd_value),
		.dest         (dest),
		.gpr_we       (gpr_we),
		.mem_we       (mem_we),
		.res_from_mem (res_from_mem),
		.mem_size     (mem_size),
		.mem_signed   (mem_signed),
		.ecode        (ecode)
	);

endmodule

/* source/operand_fetch.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module operand_fetch (
	input  logic                   clk,
	input  logic                   reset,
	decode_if.consumer             dec,
	input  logic                   wb_we,
	input  logic [`REG_ADDR_W-1:0] wb_addr,
	input  logic [`XLEN-1:0]       wb_data,
	output logic                   out_valid,
	output logic [`XLEN-1:0]       out_pc,
	output isa_pkg::alu_op_t       alu_op,
	output isa_pkg::br_kind_t      br_kind,
	output logic                   br_from_reg,
	output logic                   src1_is_pc,
	output logic                   src2_is_imm,
	output logic                   src2_is_4,
	output logic [`XLEN-1:0]       imm,
	output logic [`XLEN-1:0]       rj_value,
	output logic [`XLEN-1:0]       rkd_value,
	output logic [`REG_ADDR_W-1:0] dest,
	output logic                   gpr_we,
	output logic                   mem_we,
	output logic                   res_from_mem,
	output isa_pkg::mem_size_t     mem_size,
	output logic                   mem_signed,
	output logic [`ECODE_W-1:0]    ecode
);
	logic [`XLEN-1:0] rdata1;
	logic [`XLEN-1:0] rdata2;

	regfile u_regfile (
		.clk    (clk),
		.raddr1 (dec.raddr1),
		.raddr2 (dec.raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (wb_we),
		.waddr  (wb_addr),
		.wdata  (wb_data)
	);

	// unused operand reads as zero
	wire [`XLEN-1:0] rj_c = dec.ren1 ? rdata1 : '0;
	wire [`XLEN-1:0] rkd_c = dec.ren2 ? rdata2 : '0;

	// strobe and write enables
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			gpr_we <= 1'b0;
			mem_we <= 1'b0;
		end else begin
			out_valid <= dec.valid;
			gpr_we <= dec.valid && dec.wb.gpr_we;
			mem_we <= dec.valid && dec.wb.mem_we;
		end
	end

	// operand bundle
	always_ff @(posedge clk) begin
		if (dec.valid) begin
			out_pc <= dec.pc;
			alu_op <= dec.alu_op;
			br_kind <= dec.br_kind;
			br_from_reg <= dec.br_from_reg;
			src1_is_pc <= dec.src.src1_is_pc;
			src2_is_imm <= dec.src.src2_is_imm;
			src2_is_4 <= dec.src.src2_is_4;
			imm <= dec.imm;
			rj_value <= rj_c;
			rkd_value <= rkd_c;
			dest <= dec.dest;
			res_from_mem <= dec.wb.res_from_mem;
			mem_size <= dec.wb.mem_size;
			mem_signed <= dec.wb.mem_signed;
			ecode <= dec.ecode;
		end
	end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module regfile (
	input  logic                   clk,
	input  logic [`REG_ADDR_W-1:0] raddr1,
	input  logic [`REG_ADDR_W-1:0] raddr2,
	output logic [`XLEN-1:0]       rdata1,
	output logic [`XLEN-1:0]       rdata2,
	input  logic                   we,
	input  logic [`REG_ADDR_W-1:0] waddr,
	input  logic [`XLEN-1:0]       wdata
);
	logic [`XLEN-1:0] regs [`NUM_REGS];

	// r0 reads zero, same-cycle write is forwarded
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (we && waddr == addr)
			return wdata;
		else
			return regs[addr];
	endfunction

	// two asynchronous read ports
	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

module inst_decoder (
	input  logic                clk,
	input  logic                reset,
	input  logic                in_valid,
	input  logic [`XLEN-1:0]    inst,
	input  logic [`XLEN-1:0]    pc,
	input  logic [`ECODE_W-1:0] fetch_ecode,
	decode_if.producer          dec
);
	import isa_pkg::*;
	import ctrl_pkg::*;

	// opcode fields
	wire [5:0] op_31_26 = inst[31:26];
	wire [3:0] op_25_22 = inst[25:22];
	wire [6:0] op_21_15 = inst[21:15];

	// register numbers
	wire [`REG_ADDR_W-1:0] rd = inst[4:0];
	wire [`REG_ADDR_W-1:0] rj = inst[9:5];
	wire [`REG_ADDR_W-1:0] rk = inst[14:10];

	// immediates after extension and shift
	wire [`XLEN-1:0] si12 = {{(`XLEN-12){inst[21]}}, inst[21:10]};
	wire [`XLEN-1:0] ui12 = {{(`XLEN-12){1'b0}}, inst[21:10]};
	wire [`XLEN-1:0] ui5 = {{(`XLEN-5){1'b0}}, inst[14:10]};
	wire [`XLEN-1:0] si16 = {{(`XLEN-18){inst[25]}}, inst[25:10], 2'b00};
	wire [`XLEN-1:0] si20 = {inst[24:5], 12'h000};
	wire [`XLEN-1:0] si26 = {{(`XLEN-28){inst[9]}}, inst[9:0], inst[25:10], 2'b00};

	// holes in the minor opcode spaces
	wire alur_ok = !(op_21_15[3:0] inside {4'd1, 4'd3, 4'd6, 4'd7, 4'd12, 4'd13});
	wire sfti_ok = ({op_21_15[6:5], op_21_15[2:0]} == 5'b00001) && (op_21_15[4:3] != 2'b11);
	wire alui_ok = !(op_25_22[2:0] inside {3'd3, 3'd4});
	wire ld_ok = !({op_25_22[3], op_25_22[1:0]} inside {3'b011, 3'b110, 3'b111});
	wire st_ok = !op_25_22[3] && (op_25_22[1:0] != 2'b11);
	// jirl .. bgeu
	wire br_ok = op_31_26[3:0] inside {[4'd3:4'd11]};

	inst_class_t         cls;
	alu_op_t             alu_op_c;
	br_kind_t            br_kind_c;
	logic                br_from_reg_c;
	src_sel_t            src_c;
	wb_ctrl_t            wb_c;
	logic [`XLEN-1:0]    imm_c;
	logic                ren1_c;
	logic                ren2_c;
	logic [`ECODE_W-1:0] ecode_c;

	// bl links through r1
	wire is_bl = (cls == BRANCH) && (op_31_26[3:0] == 4'd5);
	wire [`REG_ADDR_W-1:0] dest_c = is_bl ? `REG_ADDR_W'(1) : rd;
	// branches and stores compare or store rd
	wire [`REG_ADDR_W-1:0] raddr2_c = (cls == BRANCH || cls == STORE) ? rd : rk;

	// opcode classification
	always_comb begin
		cls = INVALID;
		if (op_31_26 == 6'b000000) begin
			if (op_25_22 == 4'b0000) begin
				if (op_21_15 == 7'b1010110)
					cls = SYSCALL;
				else if (op_21_15 == 7'b1010100)
					cls = BREAK;
				else if (op_21_15 == 7'b0110000 || op_21_15[6:1] == 6'b010111)
					cls = SHIFT_REG;
				else if (op_21_15[6:4] == 3'b010 && alur_ok)
					cls = ALU_REG;
			end else if (op_25_22 == 4'b0001) begin
				if (sfti_ok)
					cls = SHIFT_IMM;
			end else if (op_25_22[3] && alui_ok) begin
				cls = ALU_IMM;
			end
		end else if (op_31_26 == 6'b000101 || op_31_26 == 6'b000111) begin
			// bit 25 belongs to the major opcode here
			if (!inst[25])
				cls = UPPER;
		end else if (op_31_26 == 6'b001010) begin
			if (!op_25_22[2] && ld_ok)
				cls = LOAD;
			else if (op_25_22[2] && st_ok)
				cls = STORE;
		end else if (op_31_26[5:4] == 2'b01 && br_ok) begin
			cls = BRANCH;
		end
	end

	// control generation per class
	always_comb begin
		alu_op_c = ADD;
		br_kind_c = NONE;
		br_from_reg_c = 1'b0;
		src_c = '0;
		wb_c = '0;
		imm_c = '0;
		ren1_c = 1'b0;
		ren2_c = 1'b0;
		case (cls)
			ALU_REG: begin
				ren1_c = 1'b1;
				ren2_c = 1'b1;
				wb_c.gpr_we = 1'b1;
				case (op_21_15[3:0])
					4'd2: alu_op_c = SUB;
					4'd4: alu_op_c = SLT;
					4'd5: alu_op_c = SLTU;
					4'd8: alu_op_c = NOR;
					4'd9: alu_op_c = AND;
					4'd10: alu_op_c = OR;
					4'd11: alu_op_c = XOR;
					default: alu_op_c = ADD;
				endcase
			end
			SHIFT_REG: begin
				ren1_c = 1'b1;
				ren2_c = 1'b1;
				wb_c.gpr_we = 1'b1;
				case (op_21_15[1:0])
					2'b10: alu_op_c = SLL;
					2'b11: alu_op_c = SRL;
					default: alu_op_c = SRA;
				endcase
			end
			ALU_IMM: begin
				ren1_c = 1'b1;
				wb_c.gpr_we = 1'b1;
				src_c.src2_is_imm = 1'b1;
				// logic ops zero extend
				imm_c = op_25_22[2] ? ui12 : si12;
				case (op_25_22[2:0])
					3'd0: alu_op_c = SLT;
					3'd1: alu_op_c = SLTU;
					3'd5: alu_op_c = AND;
					3'd6: alu_op_c = OR;
					3'd7: alu_op_c = XOR;
					default: alu_op_c = ADD;
				endcase
			end
			SHIFT_IMM: begin
				ren1_c = 1'b1;
				wb_c.gpr_we = 1'b1;
				src_c.src2_is_imm = 1'b1;
				imm_c = ui5;
				case (op_21_15[4:3])
					2'b00: alu_op_c = SLL;
					2'b01: alu_op_c = SRL;
					default: alu_op_c = SRA;
				endcase
			end
			UPPER: begin
				wb_c.gpr_we = 1'b1;
				src_c.src2_is_imm = 1'b1;
				imm_c = si20;
				// pcaddu12i adds to pc, lu12i.w passes through
				src_c.src1_is_pc = op_31_26[1];
				alu_op_c = op_31_26[1] ? ADD : LUI;
			end
			BRANCH: begin
				case (op_31_26[3:0])
					4'd3: begin
						// jirl, target from rj, links pc+4
						br_kind_c = ALWAYS;
						br_from_reg_c = 1'b1;
						ren1_c = 1'b1;
						src_c.src1_is_pc = 1'b1;
						src_c.src2_is_4 = 1'b1;
						wb_c.gpr_we = 1'b1;
						imm_c = si16;
					end
					4'd4: begin
						br_kind_c = ALWAYS;
						imm_c = si26;
					end
					4'd5: begin
						br_kind_c = ALWAYS;
						src_c.src1_is_pc = 1'b1;
						src_c.src2_is_4 = 1'b1;
						wb_c.gpr_we = 1'b1;
						imm_c = si26;
					end
					default: begin
						// conditional, odd opcodes take the inverted sense
						ren1_c = 1'b1;
						ren2_c = 1'b1;
						imm_c = si16;
						br_kind_c = op_31_26[0] ? IF_FALSE : IF_TRUE;
						if (op_31_26[3:1] == 3'b011)
							alu_op_c = EQ;
						else
							alu_op_c = op_31_26[1] ? SLTU : SLT;
					end
				endcase
			end
			LOAD: begin
				ren1_c = 1'b1;
				src_c.src2_is_imm = 1'b1;
				imm_c = si12;
				wb_c.gpr_we = 1'b1;
				wb_c.res_from_mem = 1'b1;
				wb_c.mem_size = mem_size_t'(op_25_22[1:0]);
				// ld.bu and ld.hu have bit 25 set
				wb_c.mem_signed = !op_25_22[3];
			end
			STORE: begin
				ren1_c = 1'b1;
				ren2_c = 1'b1;
				src_c.src2_is_imm = 1'b1;
				imm_c = si12;
				wb_c.mem_we = 1'b1;
				wb_c.mem_size = mem_size_t'(op_25_22[1:0]);
			end
			default: begin
			end
		endcase

		// fetch exception wins over anything found here
		if (fetch_ecode != `ECODE_NONE)
			ecode_c = fetch_ecode;
		else if (cls == SYSCALL)
			ecode_c = `ECODE_SYS;
		else if (cls == BREAK)
			ecode_c = `ECODE_BRK;
		else if (cls == INVALID)
			ecode_c = `ECODE_INE;
		else
			ecode_c = `ECODE_NONE;

		// excepting instruction must leave no side effect
		if (ecode_c != `ECODE_NONE) begin
			wb_c.gpr_we = 1'b0;
			wb_c.mem_we = 1'b0;
		end
	end

	// strobe and write controls, cleared between strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			dec.valid <= 1'b0;
			dec.wb <= '0;
		end else begin
			dec.valid <= in_valid;
			dec.wb <= in_valid ? wb_c : '0;
		end
	end

	// payload, loaded on the strobe only
	always_ff @(posedge clk) begin
		if (in_valid) begin
			dec.pc <= pc;
			dec.alu_op <= alu_op_c;
			dec.br_kind <= br_kind_c;
			dec.br_from_reg <= br_from_reg_c;
			dec.src <= src_c;
			dec.imm <= imm_c;
			dec.dest <= dest_c;
			dec.ecode <= ecode_c;
			dec.raddr1 <= rj;
			dec.raddr2 <= raddr2_c;
			dec.ren1 <= ren1_c;
			dec.ren2 <= ren2_c;
		end
	end

endmodule

/* source/decode_if.sv */
`timescale 1ns/1ns
`include "decode_consts.svh"

interface decode_if;
	import isa_pkg::*;
	import ctrl_pkg::*;

	// decoded control, one entry per strobe
	logic                   valid;
	logic [`XLEN-1:0]       pc;
	alu_op_t                alu_op;
	br_kind_t               br_kind;
	logic                   br_from_reg;
	src_sel_t               src;
	wb_ctrl_t               wb;
	logic [`XLEN-1:0]       imm;
	logic [`REG_ADDR_W-1:0] dest;
	logic [`ECODE_W-1:0]    ecode;
	// register file read request
	logic [`REG_ADDR_W-1:0] raddr1;
	logic [`REG_ADDR_W-1:0] raddr2;
	logic                   ren1;
	logic                   ren2;

	modport producer (output valid, pc, alu_op, br_kind, br_from_reg, src, wb, imm, dest,
		ecode, raddr1, raddr2, ren1, ren2);
	modport consumer (input valid, pc, alu_op, br_kind, br_from_reg, src, wb, imm, dest,
		ecode, raddr1, raddr2, ren1, ren2);

endinterface

/* source/ctrl_pkg.sv */
package ctrl_pkg;

	// alu operand source selects
	typedef struct packed {
		// pc instead of rj
		logic src1_is_pc;
		// immediate instead of rk/rd
		logic src2_is_imm;
		// constant 4 for link address
		logic src2_is_4;
	} src_sel_t;

	// memory and write-back control
	typedef struct packed {
		// register write enable
		logic                gpr_we;
		// memory write enable
		logic                mem_we;
		// load result goes to the register
		logic                res_from_mem;
		// access size of ld/st
		isa_pkg::mem_size_t  mem_size;
		// sign extend the loaded value
		logic                mem_signed;
	} wb_ctrl_t;

endpackage

/* source/isa_pkg.sv */
package isa_pkg;

	// alu operations, numbered as the execute stage expects
	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		SLT  = 4'd2,
		SLTU = 4'd3,
		AND  = 4'd4,
		NOR  = 4'd5,
		OR   = 4'd6,
		XOR  = 4'd7,
		SLL  = 4'd8,
		SRL  = 4'd9,
		SRA  = 4'd10,
		// passes the shifted immediate through
		LUI  = 4'd11,
		// equality compare for beq/bne
		EQ   = 4'd12
	} alu_op_t;

	// coarse opcode classes
	typedef enum logic [3:0] {
		ALU_REG   = 4'd0,
		SHIFT_REG = 4'd1,
		ALU_IMM   = 4'd2,
		SHIFT_IMM = 4'd3,
		// lu12i.w and pcaddu12i
		UPPER     = 4'd4,
		BRANCH    = 4'd5,
		LOAD      = 4'd6,
		STORE     = 4'd7,
		SYSCALL   = 4'd8,
		BREAK     = 4'd9,
		// reserved or unsupported encoding
		INVALID   = 4'd10
	} inst_class_t;

	// access size, same code as inst[23:22] of ld/st
	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} mem_size_t;

	// branch condition, resolved against the alu result
	typedef enum logic [1:0] {
		NONE     = 2'd0,
		ALWAYS   = 2'd1,
		IF_TRUE  = 2'd2,
		IF_FALSE = 2'd3
	} br_kind_t;

endpackage

/* source/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// datapath width
`define XLEN        32

// register file geometry
`define REG_ADDR_W  5
`define NUM_REGS    32

// exception code width
`define ECODE_W     6

// no exception
`define ECODE_NONE  6'h00
// syscall
`define ECODE_SYS   6'h0b
// break
`define ECODE_BRK   6'h0c
// reserved instruction
`define ECODE_INE   6'h0d

`endif
